/* source/axi_remap_pkg.sv */
/*
  Shared widths and types of the AXI read ID remapper.
  NUM_OUT_IDS follows OUT_ID_W, and every downstream ID value names a slot.
  A slot counts at most MAX_CNT outstanding bursts and stalls beyond that.
*/
package axi_remap_pkg;

  // Upstream and downstream ID widths
  localparam int IN_ID_W  = 4;
  localparam int OUT_ID_W = 2;

  // One slot per downstream ID value
  localparam int NUM_OUT_IDS = 2 ** OUT_ID_W;

  // Request and response payload widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int LEN_W  = 4;

  // Outstanding burst counter per slot
  localparam int CNT_W = 3;

  typedef logic [IN_ID_W-1:0]  in_id_t;
  typedef logic [OUT_ID_W-1:0] out_id_t;
  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;

  // Beats in a burst are len + 1
  typedef logic [LEN_W-1:0]    len_t;

  typedef logic [CNT_W-1:0]    cnt_t;

  // A slot holding this many bursts accepts no more
  localparam cnt_t MAX_CNT = cnt_t'(7);

endpackage

/* source/axi_ar_if.sv */
/*
  AR channel bundle with valid/ready handshake.
  The id type is a parameter so one bundle serves both ID widths.
*/
`timescale 1ns/1ps

interface axi_ar_if #(
  parameter type id_t = logic
);

  logic                 valid;
  logic                 ready;
  id_t                  id;
  axi_remap_pkg::addr_t addr;
  axi_remap_pkg::len_t  len;

  // Request issuer
  modport master (
    output valid, id, addr, len,
    input  ready
  );

  // Request receiver
  modport slave (
    input  valid, id, addr, len,
    output ready
  );

endinterface

/* source/axi_r_if.sv */
/*
  R channel bundle with valid/ready handshake.
  The id type is a parameter so one bundle serves both ID widths.
*/
`timescale 1ns/1ps

interface axi_r_if #(
  parameter type id_t = logic
);

  logic                 valid;
  logic                 ready;
  id_t                  id;
  axi_remap_pkg::data_t data;
  logic                 last;

  // Beat source
  modport master (
    output valid, id, data, last,
    input  ready
  );

  // Beat sink
  modport slave (
    input  valid, id, data, last,
    output ready
  );

endinterface

/* source/remap_table_if.sv */
/*
  Link between the slot table and the AR and R paths.
  Allocate and release are one-cycle strobes applied at the next clock.
*/
`timescale 1ns/1ps

interface remap_table_if;

  // Slot contents, one entry per downstream ID
  axi_remap_pkg::in_id_t [axi_remap_pkg::NUM_OUT_IDS-1:0] entry_in_id;
  axi_remap_pkg::cnt_t   [axi_remap_pkg::NUM_OUT_IDS-1:0] entry_cnt;

  // Burst issued downstream
  logic                    alloc_valid;
  axi_remap_pkg::out_id_t  alloc_slot;
  axi_remap_pkg::in_id_t   alloc_in_id;

  // Last beat returned upstream
  logic                    release_valid;
  axi_remap_pkg::out_id_t  release_slot;

  modport slots (
    output entry_in_id, entry_cnt,
    input  alloc_valid, alloc_slot, alloc_in_id, release_valid, release_slot
  );

  modport ar (
    input  entry_in_id, entry_cnt,
    output alloc_valid, alloc_slot, alloc_in_id
  );

  modport r (
    input  entry_in_id, entry_cnt,
    output release_valid, release_slot
  );

endinterface

/* source/remap_table.sv */
/*
  Slot table of the ID remapper. Each slot holds the owning upstream ID and
  the number of bursts still outstanding. A slot with count zero is free and
  its owner is stale until the next allocate. Allocate and release on one
  slot in the same cycle cancel out.
*/
`timescale 1ns/1ps

module remap_table (
  input logic          clk_i,
  input logic          arst_n_i,
  remap_table_if.slots tbl
);

  axi_remap_pkg::cnt_t   [axi_remap_pkg::NUM_OUT_IDS-1:0] cnt_q;
  axi_remap_pkg::in_id_t [axi_remap_pkg::NUM_OUT_IDS-1:0] owner_q;

  for (genvar i = 0; i < axi_remap_pkg::NUM_OUT_IDS; i++) begin : gen_slot
    logic inc;
    logic dec;

    assign inc = tbl.alloc_valid &&
                 (tbl.alloc_slot == axi_remap_pkg::out_id_t'(i));
    assign dec = tbl.release_valid &&
                 (tbl.release_slot == axi_remap_pkg::out_id_t'(i));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        cnt_q[i] <= '0;
      end else if (inc && !dec) begin
        cnt_q[i] <= cnt_q[i] + axi_remap_pkg::cnt_t'(1);
      end else if (dec && !inc) begin
        cnt_q[i] <= cnt_q[i] - axi_remap_pkg::cnt_t'(1);
      end
    end

    // Owner rewritten on every allocate, reuse writes the same value
    always_ff @(posedge clk_i) begin
      if (inc) begin
        owner_q[i] <= tbl.alloc_in_id;
      end
    end
  end

  assign tbl.entry_cnt   = cnt_q;
  assign tbl.entry_in_id = owner_q;

  // The R path only releases slots the AR path has filled
  a_release_nonzero: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    tbl.release_valid |-> (cnt_q[tbl.release_slot] != '0)
  ) else $error("release on empty slot %0d", tbl.release_slot);

  // The AR path must stall before a slot counter would wrap
  a_alloc_not_full: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    tbl.alloc_valid |-> (cnt_q[tbl.alloc_slot] != axi_remap_pkg::MAX_CNT)
  ) else $error("allocate on full slot %0d", tbl.alloc_slot);

endmodule

/* source/remap_ar_path.sv */
/*
  AR side of the remapper, combinational from upstream to downstream.
  An ID that owns a slot reuses it and stalls at MAX_CNT, a new ID takes
  the lowest free slot and stalls when none is free. A stalled-on-ready
  request keeps its slot, so the upstream master must hold valid and payload.
*/
`timescale 1ns/1ps

module remap_ar_path (
  input logic       clk_i,
  input logic       arst_n_i,
  axi_ar_if.slave   up,
  axi_ar_if.master  dn,
  remap_table_if.ar tbl
);

  logic                   hit;
  logic                   free_found;
  axi_remap_pkg::out_id_t hit_slot;
  axi_remap_pkg::out_id_t free_slot;
  logic                   slot_ok;
  axi_remap_pkg::out_id_t slot;
  logic                   hold_q;
  axi_remap_pkg::out_id_t hold_slot_q;

  // Descending scan so the lowest matching slot wins
  always_comb begin
    hit        = 1'b0;
    free_found = 1'b0;
    hit_slot   = '0;
    free_slot  = '0;
    for (int i = axi_remap_pkg::NUM_OUT_IDS - 1; i >= 0; i--) begin
      if ((tbl.entry_cnt[i] != '0) && (tbl.entry_in_id[i] == up.id)) begin
        hit      = 1'b1;
        hit_slot = axi_remap_pkg::out_id_t'(i);
      end
      if (tbl.entry_cnt[i] == '0) begin
        free_found = 1'b1;
        free_slot  = axi_remap_pkg::out_id_t'(i);
      end
    end
  end

  // A waiting request cannot lose its slot, only this path allocates
  always_comb begin
    if (hold_q) begin
      slot    = hold_slot_q;
      slot_ok = 1'b1;
    end else if (hit) begin
      slot    = hit_slot;
      slot_ok = (tbl.entry_cnt[hit_slot] != axi_remap_pkg::MAX_CNT);
    end else begin
      slot    = free_slot;
      slot_ok = free_found;
    end
  end

  assign dn.valid = up.valid && slot_ok;
  assign up.ready = dn.ready && slot_ok;
  assign dn.id    = slot;
  assign dn.addr  = up.addr;
  assign dn.len   = up.len;

  assign tbl.alloc_valid = dn.valid && dn.ready;
  assign tbl.alloc_slot  = slot;
  assign tbl.alloc_in_id = up.id;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hold_q <= 1'b0;
    end else begin
      hold_q <= dn.valid && !dn.ready;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dn.valid && !dn.ready) begin
      hold_slot_q <= slot;
    end
  end

  a_dn_stable: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (dn.valid && !dn.ready) |=>
      (dn.valid && $stable(dn.id) && $stable(dn.addr) && $stable(dn.len))
  ) else $error("downstream AR changed while waiting for ready");

endmodule

/* source/remap_r_path.sv */
/*
  R side of the remapper, combinational with no buffering.
  Ready passes straight back downstream. Each transferred last beat
  releases one burst from its slot.
*/
`timescale 1ns/1ps

module remap_r_path (
  input logic      clk_i,
  input logic      arst_n_i,
  axi_r_if.slave   dn,
  axi_r_if.master  up,
  remap_table_if.r tbl
);

  logic beat_done;

  assign beat_done = dn.valid && up.ready;

  // Slot owner gives back the upstream ID
  assign up.valid = dn.valid;
  assign up.id    = tbl.entry_in_id[dn.id];
  assign up.data  = dn.data;
  assign up.last  = dn.last;
  assign dn.ready = up.ready;

  assign tbl.release_valid = beat_done && dn.last;
  assign tbl.release_slot  = dn.id;

  // Downstream slave answers only IDs that were issued
  a_beat_owned: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    dn.valid |-> (tbl.entry_cnt[dn.id] != '0)
  ) else $error("R beat on unallocated downstream ID %0d", dn.id);

endmodule

/* source/axi_id_remap.sv */
/*
  AXI read ID remapper, 4-bit upstream IDs onto 2-bit downstream IDs.
  AR and R pass combinationally. Read channels only, no size, burst,
  cache, protection or response fields.
*/
`timescale 1ns/1ps

module axi_id_remap (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // Upstream slave port
  input  logic                    s_ar_valid_i,
  output logic                    s_ar_ready_o,
  input  axi_remap_pkg::in_id_t   s_ar_id_i,
  input  axi_remap_pkg::addr_t    s_ar_addr_i,
  input  axi_remap_pkg::len_t     s_ar_len_i,
  output logic                    s_r_valid_o,
  input  logic                    s_r_ready_i,
  output axi_remap_pkg::in_id_t   s_r_id_o,
  output axi_remap_pkg::data_t    s_r_data_o,
  output logic                    s_r_last_o,
  // Downstream master port
  output logic                    m_ar_valid_o,
  input  logic                    m_ar_ready_i,
  output axi_remap_pkg::out_id_t  m_ar_id_o,
  output axi_remap_pkg::addr_t    m_ar_addr_o,
  output axi_remap_pkg::len_t     m_ar_len_o,
  input  logic                    m_r_valid_i,
  output logic                    m_r_ready_o,
  input  axi_remap_pkg::out_id_t  m_r_id_i,
  input  axi_remap_pkg::data_t    m_r_data_i,
  input  logic                    m_r_last_i
);

  axi_ar_if #(.id_t(axi_remap_pkg::in_id_t))  ar_up ();
  axi_ar_if #(.id_t(axi_remap_pkg::out_id_t)) ar_dn ();
  axi_r_if  #(.id_t(axi_remap_pkg::out_id_t)) r_dn ();
  axi_r_if  #(.id_t(axi_remap_pkg::in_id_t))  r_up ();
  remap_table_if                              tbl ();

  assign ar_up.valid  = s_ar_valid_i;
  assign ar_up.id     = s_ar_id_i;
  assign ar_up.addr   = s_ar_addr_i;
  assign ar_up.len    = s_ar_len_i;
  assign s_ar_ready_o = ar_up.ready;

  assign m_ar_valid_o = ar_dn.valid;
  assign m_ar_id_o    = ar_dn.id;
  assign m_ar_addr_o  = ar_dn.addr;
  assign m_ar_len_o   = ar_dn.len;
  assign ar_dn.ready  = m_ar_ready_i;

  assign r_dn.valid   = m_r_valid_i;
  assign r_dn.id      = m_r_id_i;
  assign r_dn.data    = m_r_data_i;
  assign r_dn.last    = m_r_last_i;
  assign m_r_ready_o  = r_dn.ready;

  assign s_r_valid_o  = r_up.valid;
  assign s_r_id_o     = r_up.id;
  assign s_r_data_o   = r_up.data;
  assign s_r_last_o   = r_up.last;
  assign r_up.ready   = s_r_ready_i;

  remap_table u_table (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .tbl      (tbl.slots)
  );

  remap_ar_path u_ar_path (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .up       (ar_up.slave),
    .dn       (ar_dn.master),
    .tbl      (tbl.ar)
  );

  remap_r_path u_r_path (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .dn       (r_dn.slave),
    .up       (r_up.master),
    .tbl      (tbl.r)
  );

endmodule

/* test/remap_compare.sv */
/*
  Scoreboard for the AXI read ID remapper. Watches both sides of the DUT
  and samples on the rising clock, when all inputs are stable.
  Expected R data comes from ref_data and the addresses seen upstream.
*/
`timescale 1ns/1ps

module remap_compare (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  // Upstream side of the DUT
  input  logic                   s_ar_valid_i,
  input  logic                   s_ar_ready_i,
  input  axi_remap_pkg::in_id_t  s_ar_id_i,
  input  axi_remap_pkg::addr_t   s_ar_addr_i,
  input  axi_remap_pkg::len_t    s_ar_len_i,
  input  logic                   s_r_valid_i,
  input  logic                   s_r_ready_i,
  input  axi_remap_pkg::in_id_t  s_r_id_i,
  input  axi_remap_pkg::data_t   s_r_data_i,
  input  logic                   s_r_last_i,
  // Downstream side of the DUT
  input  logic                   m_ar_valid_i,
  input  logic                   m_ar_ready_i,
  input  axi_remap_pkg::out_id_t m_ar_id_i,
  input  axi_remap_pkg::addr_t   m_ar_addr_i,
  input  axi_remap_pkg::len_t    m_ar_len_i,
  input  logic                   m_r_valid_i,
  input  logic                   m_r_ready_i,
  output int unsigned            mismatch_cnt_o,
  output int unsigned            other_cnt_o,
  output int unsigned            pending_o
);

  localparam int NUM_IN_IDS = 16;

  int unsigned            mismatch_cnt = 0;
  int unsigned            other_cnt = 0;
  int unsigned            pending = 0;
  // Expected bursts per upstream ID, oldest first
  axi_remap_pkg::addr_t   exp_addr [NUM_IN_IDS][$];
  axi_remap_pkg::len_t    exp_len [NUM_IN_IDS][$];
  int                     beat [NUM_IN_IDS] = '{default: 0};
  axi_remap_pkg::out_id_t dn_id [NUM_IN_IDS];

  // Beat data of the slave model
  function automatic axi_remap_pkg::data_t ref_data(input axi_remap_pkg::addr_t addr,
                                                    input int idx);
    return (axi_remap_pkg::data_t'(addr) + axi_remap_pkg::data_t'(idx)) ^
           (axi_remap_pkg::data_t'(addr) << 16);
  endfunction

  task automatic flag_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    mismatch_cnt++;
    $display("mismatch %s got %h expected %h at %0t", name, got, exp, $time);
  endtask

  task automatic flag_error(input string text);
    other_cnt++;
    $display("%s at %0t", text, $time);
  endtask

  always @(posedge clk_i) begin : compare
    int  held;
    int  total;
    logic last_exp;
    held  = 0;
    total = 0;
    if (arst_n_i) begin
      // Both AR sides transfer together since the path is combinational
      if ((s_ar_valid_i && s_ar_ready_i) != (m_ar_valid_i && m_ar_ready_i)) begin
        flag_error("AR transfer seen on only one side of the DUT");
      end
      if (s_ar_valid_i && s_ar_ready_i) begin
        if (m_ar_addr_i != s_ar_addr_i) begin
          flag_mismatch("m_ar_addr_o", 32'(m_ar_addr_i), 32'(s_ar_addr_i));
        end
        if (m_ar_len_i != s_ar_len_i) begin
          flag_mismatch("m_ar_len_o", 32'(m_ar_len_i), 32'(s_ar_len_i));
        end
        // An ID with bursts in flight keeps its downstream ID
        if (exp_addr[s_ar_id_i].size() != 0 && m_ar_id_i != dn_id[s_ar_id_i]) begin
          flag_mismatch("m_ar_id_o", 32'(m_ar_id_i), 32'(dn_id[s_ar_id_i]));
        end
        dn_id[s_ar_id_i] = m_ar_id_i;
        exp_addr[s_ar_id_i].push_back(s_ar_addr_i);
        exp_len[s_ar_id_i].push_back(s_ar_len_i);
      end
      if (m_r_ready_i != s_r_ready_i) begin
        flag_mismatch("m_r_ready_o", 32'(m_r_ready_i), 32'(s_r_ready_i));
      end
      if (s_r_valid_i != m_r_valid_i) begin
        flag_mismatch("s_r_valid_o", 32'(s_r_valid_i), 32'(m_r_valid_i));
      end
      if (s_r_valid_i && s_r_ready_i) begin
        if (exp_addr[s_r_id_i].size() == 0) begin
          flag_error($sformatf("R beat for upstream ID %0h with no burst outstanding",
                               s_r_id_i));
        end else begin
          if (s_r_data_i != ref_data(exp_addr[s_r_id_i][0], beat[s_r_id_i])) begin
            flag_mismatch("s_r_data_o", s_r_data_i,
                          ref_data(exp_addr[s_r_id_i][0], beat[s_r_id_i]));
          end
          last_exp = (beat[s_r_id_i] == int'(exp_len[s_r_id_i][0]));
          if (s_r_last_i != last_exp) begin
            flag_mismatch("s_r_last_o", 32'(s_r_last_i), 32'(last_exp));
          end
          if (last_exp) begin
            void'(exp_addr[s_r_id_i].pop_front());
            void'(exp_len[s_r_id_i].pop_front());
            beat[s_r_id_i] = 0;
          end else begin
            beat[s_r_id_i]++;
          end
        end
      end
      for (int i = 0; i < NUM_IN_IDS; i++) begin
        if (exp_addr[i].size() != 0) begin
          held++;
        end
        if (exp_addr[i].size() > int'(axi_remap_pkg::MAX_CNT)) begin
          flag_error($sformatf("Upstream ID %0h has more bursts outstanding than allowed", i));
        end
        total += exp_addr[i].size();
      end
      if (held > axi_remap_pkg::NUM_OUT_IDS) begin
        flag_error("More upstream IDs outstanding than downstream IDs exist");
      end
      pending = total;
    end
  end

  assign mismatch_cnt_o = mismatch_cnt;
  assign other_cnt_o    = other_cnt;
  assign pending_o      = pending;

endmodule

/* test/tb_axi_id_remap.sv */
/*
  Testbench for the AXI read ID remapper. Inputs change on the falling
  clock edge. The slave model answers bursts from one FIFO per downstream
  ID, interleaved across IDs and in order within one.
*/
`timescale 1ns/1ps

module tb_axi_id_remap;

  localparam int          NUM_REQ    = 200;
  localparam int          MAX_CYCLES = NUM_REQ * 16 * 8;
  localparam logic [31:0] SEED       = 32'hbb63_ba5d;

  logic clk_i;
  logic arst_n_i;
  logic s_ar_valid_i, s_ar_ready_o, s_r_valid_o, s_r_ready_i, s_r_last_o;
  logic m_ar_valid_o, m_ar_ready_i, m_r_valid_i, m_r_ready_o, m_r_last_i;
  axi_remap_pkg::in_id_t  s_ar_id_i, s_r_id_o;
  axi_remap_pkg::out_id_t m_ar_id_o, m_r_id_i;
  axi_remap_pkg::addr_t   s_ar_addr_i, m_ar_addr_o;
  axi_remap_pkg::len_t    s_ar_len_i, m_ar_len_o;
  axi_remap_pkg::data_t   s_r_data_o, m_r_data_i;

  int unsigned mismatch_cnt, other_cnt, pending;
  int unsigned tb_err = 0;
  int unsigned cycles = 0;
  int unsigned last_seen = 0;
  logic [31:0] stim_lfsr, env_lfsr;
  logic        hold_resp, force_ar_ready;
  logic        r_xfer_q = 1'b0;
  // Slave model bursts per downstream ID
  axi_remap_pkg::addr_t fifo_addr [axi_remap_pkg::NUM_OUT_IDS][$];
  axi_remap_pkg::len_t  fifo_len [axi_remap_pkg::NUM_OUT_IDS][$];
  int                   beat_idx [axi_remap_pkg::NUM_OUT_IDS] = '{default: 0};

  axi_id_remap DUT (.*);

  remap_compare u_checker (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .s_ar_valid_i   (s_ar_valid_i),
    .s_ar_ready_i   (s_ar_ready_o),
    .s_ar_id_i      (s_ar_id_i),
    .s_ar_addr_i    (s_ar_addr_i),
    .s_ar_len_i     (s_ar_len_i),
    .s_r_valid_i    (s_r_valid_o),
    .s_r_ready_i    (s_r_ready_i),
    .s_r_id_i       (s_r_id_o),
    .s_r_data_i     (s_r_data_o),
    .s_r_last_i     (s_r_last_o),
    .m_ar_valid_i   (m_ar_valid_o),
    .m_ar_ready_i   (m_ar_ready_i),
    .m_ar_id_i      (m_ar_id_o),
    .m_ar_addr_i    (m_ar_addr_o),
    .m_ar_len_i     (m_ar_len_o),
    .m_r_valid_i    (m_r_valid_i),
    .m_r_ready_i    (m_r_ready_o),
    .mismatch_cnt_o (mismatch_cnt),
    .other_cnt_o    (other_cnt),
    .pending_o      (pending)
  );

  function automatic axi_remap_pkg::data_t ref_data(input axi_remap_pkg::addr_t addr,
                                                    input int idx);
    return (axi_remap_pkg::data_t'(addr) + axi_remap_pkg::data_t'(idx)) ^
           (axi_remap_pkg::data_t'(addr) << 16);
  endfunction

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] r);
    r = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_step(state);
      r = {r[30:0], state[0]};
    end
  endtask

  // Holds the request until ready, starts and ends on a falling edge
  task automatic send_ar(input axi_remap_pkg::in_id_t id, input axi_remap_pkg::addr_t addr,
                         input axi_remap_pkg::len_t len, output int unsigned lasts);
    s_ar_valid_i = 1'b1;
    s_ar_id_i    = id;
    s_ar_addr_i  = addr;
    s_ar_len_i   = len;
    #1;
    while (!s_ar_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    lasts = last_seen;
    @(negedge clk_i);
    s_ar_valid_i = 1'b0;
  endtask

  // Presents a request no slot can take while responses are held back,
  // then lets responses flow and completes it once a last beat frees room
  task automatic send_after_stall(input axi_remap_pkg::in_id_t id,
                                  input axi_remap_pkg::addr_t addr, input string what);
    int unsigned start;
    int unsigned lasts;
    s_ar_valid_i = 1'b1;
    s_ar_id_i    = id;
    s_ar_addr_i  = addr;
    s_ar_len_i   = 4'd3;
    repeat (12) begin
      #1;
      if (s_ar_ready_o) begin
        tb_err++;
        $display("%s accepted while responses were held at %0t", what, $time);
      end
      @(negedge clk_i);
    end
    // Responses resume from the next falling edge on
    #1;
    start          = last_seen;
    hold_resp      = 1'b0;
    force_ar_ready = 1'b0;
    @(negedge clk_i);
    send_ar(id, addr, 4'd3, lasts);
    if (lasts == start) begin
      tb_err++;
      $display("%s accepted before any last beat freed room", what);
    end
  endtask

  initial begin : clock
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin : timeout
    cycles++;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout after %0d cycles with %0d bursts still outstanding", cycles, pending);
      $display("Finished with errors");
      $finish;
    end
  end

  // Slave model bookkeeping on completed transfers
  always @(posedge clk_i) begin : slave_track
    r_xfer_q = m_r_valid_i && m_r_ready_o;
    if (m_ar_valid_o && m_ar_ready_i) begin
      fifo_addr[m_ar_id_o].push_back(m_ar_addr_o);
      fifo_len[m_ar_id_o].push_back(m_ar_len_o);
    end
    if (m_r_valid_i && m_r_ready_o) begin
      if (m_r_last_i) begin
        void'(fifo_addr[m_r_id_i].pop_front());
        void'(fifo_len[m_r_id_i].pop_front());
        beat_idx[m_r_id_i] = 0;
        last_seen++;
      end else begin
        beat_idx[m_r_id_i]++;
      end
    end
  end

  initial begin : slave_drive
    logic [31:0] r;
    int          s;
    env_lfsr     = SEED;
    m_ar_ready_i = 1'b0;
    s_r_ready_i  = 1'b0;
    m_r_valid_i  = 1'b0;
    m_r_id_i     = '0;
    m_r_data_i   = '0;
    m_r_last_i   = 1'b0;
    forever begin
      @(negedge clk_i);
      draw_bits(env_lfsr, 2, r);
      s_r_ready_i = (r[1:0] != 2'b00);
      draw_bits(env_lfsr, 1, r);
      m_ar_ready_i = force_ar_ready || r[0];
      // A beat not yet taken keeps its payload
      if (!m_r_valid_i || r_xfer_q) begin
        m_r_valid_i = 1'b0;
        draw_bits(env_lfsr, 3, r);
        for (int k = 0; k < axi_remap_pkg::NUM_OUT_IDS; k++) begin
          s = (int'(r[1:0]) + k) % axi_remap_pkg::NUM_OUT_IDS;
          if (!hold_resp && r[2] && !m_r_valid_i && fifo_addr[s].size() != 0) begin
            m_r_valid_i = 1'b1;
            m_r_id_i    = axi_remap_pkg::out_id_t'(s);
            m_r_data_i  = ref_data(fifo_addr[s][0], beat_idx[s]);
            m_r_last_i  = (beat_idx[s] == int'(fifo_len[s][0]));
          end
        end
      end
    end
  end

  initial begin : stimulus
    logic [31:0]           r;
    axi_remap_pkg::in_id_t id;
    axi_remap_pkg::addr_t  addr;
    int unsigned           lasts;
    stim_lfsr      = SEED;
    arst_n_i       = 1'b0;
    s_ar_valid_i   = 1'b0;
    s_ar_id_i      = '0;
    s_ar_addr_i    = '0;
    s_ar_len_i     = '0;
    hold_resp      = 1'b1;
    force_ar_ready = 1'b1;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    // Four IDs take every slot while responses are held back
    for (int i = 1; i <= 4; i++) begin
      send_ar(axi_remap_pkg::in_id_t'(i), axi_remap_pkg::addr_t'(i * 256), 4'd3, lasts);
    end
    send_after_stall(4'd5, 16'h0500, "Fifth upstream ID");
    for (int n = 0; n < NUM_REQ; n++) begin
      draw_bits(stim_lfsr, 2, r);
      repeat (int'(r[1:0])) @(negedge clk_i);
      draw_bits(stim_lfsr, 4, r);
      id = axi_remap_pkg::in_id_t'(r[3:0]);
      draw_bits(stim_lfsr, 16, r);
      addr = axi_remap_pkg::addr_t'(r[15:0]);
      draw_bits(stim_lfsr, 4, r);
      send_ar(id, addr, axi_remap_pkg::len_t'(r[3:0]), lasts);
    end
    while (pending != 0) begin
      @(negedge clk_i);
    end
    // One ID fills its slot to MAX_CNT while responses are held back
    #1;
    hold_resp      = 1'b1;
    force_ar_ready = 1'b1;
    @(negedge clk_i);
    for (int i = 0; i < int'(axi_remap_pkg::MAX_CNT); i++) begin
      send_ar(4'd6, axi_remap_pkg::addr_t'(16'h0600 + i * 16), 4'd3, lasts);
    end
    send_after_stall(4'd6, 16'h0680, "Upstream ID beyond its burst limit");
    while (pending != 0) begin
      @(negedge clk_i);
    end
    repeat (4) @(negedge clk_i);
    for (int s = 0; s < axi_remap_pkg::NUM_OUT_IDS; s++) begin
      if (fifo_addr[s].size() != 0) begin
        tb_err++;
        $display("Slave model still holds unanswered bursts on downstream ID %0d", s);
      end
    end
    $display("Mismatches %0d, other errors %0d", mismatch_cnt, other_cnt + tb_err);
    if (mismatch_cnt == 0 && other_cnt + tb_err == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* compile.f */
source/axi_remap_pkg.sv
source/axi_ar_if.sv
source/axi_r_if.sv
source/remap_table_if.sv
source/remap_table.sv
source/remap_ar_path.sv
source/remap_r_path.sv
source/axi_id_remap.sv
test/remap_compare.sv
test/tb_axi_id_remap.sv

/* Makefile */
# Verilator flow for the AXI read ID remapper

TOP := tb_axi_id_remap

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module axi_id_remap -f compile.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -qx "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
